/* include/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define XLEN        32
`define SQN_WIDTH   7   // ages compare by signed modular difference
`define TAG_WIDTH   6
`define OP_WIDTH    5

// alu
`define OP_ADD      5'd0
`define OP_SUB      5'd1
`define OP_AND      5'd2
`define OP_OR       5'd3
`define OP_XOR      5'd4
`define OP_SLT      5'd5
`define OP_SLTU     5'd6
`define OP_SLL      5'd7
`define OP_SRL      5'd8
`define OP_SRA      5'd9

// branches
`define OP_BEQ      5'd10
`define OP_BNE      5'd11
`define OP_BLT      5'd12
`define OP_BGE      5'd13
`define OP_BLTU     5'd14
`define OP_BGEU     5'd15

`define OP_MUL      5'd16
`define OP_MULH     5'd17
`define OP_MULHU    5'd18
`define OP_DIV      5'd19
`define OP_DIVU     5'd20
`define OP_REM      5'd21
`define OP_REMU     5'd22

`define MUL_LATENCY 3
`define DIV_LATENCY 33

`endif

/* sources.f */
+incdir+include
src/execPkg.sv
src/intAlu.sv
src/divider.sv
src/multiplier.sv
src/aluDivLane.sv
src/aluMulLane.sv
src/branchSelector.sv
src/intExecCluster.sv
verification/clusterTb.sv

/* src/aluDivLane.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module aluDivLane (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    issueValid,
    input  wire [`OP_WIDTH-1:0]    issueOp,
    input  wire [`SQN_WIDTH-1:0]   issueSqN,
    input  wire [`TAG_WIDTH-1:0]   issueTag,
    input  wire [`XLEN-1:0]        issuePc,
    input  wire [`XLEN-1:0]        srcA,
    input  wire [`XLEN-1:0]        srcB,
    input  execPkg::OperandWord    imm,
    input  wire                    flushTaken,
    input  wire [`SQN_WIDTH-1:0]   flushSqN,
    output logic                   doNotIssue,
    output logic                   wbValid,
    output logic [`TAG_WIDTH-1:0]  wbTag,
    output logic [`XLEN-1:0]       wbResult,
    output logic                   provTaken,
    output logic [`SQN_WIDTH-1:0]  provSqN,
    output logic [`XLEN-1:0]       provTarget
);
    import execPkg::*;

    logic aluValid, aluLive, divValid, divBusy, isDiv, startDiv;
    logic [`TAG_WIDTH-1:0] aluTag, divTag;
    logic [`SQN_WIDTH-1:0] aluSqN;
    logic [`XLEN-1:0] aluResult, divResult;

    assign isDiv = (issueOp >= `OP_DIV) && (issueOp <= `OP_REMU);
    assign startDiv = issueValid && isDiv && !(flushTaken && isYounger(issueSqN, flushSqN));

    intAlu alu_i (
        .clk(clk), .reset(reset),
        .issueValid(issueValid), .op(issueOp), .sqN(issueSqN), .tag(issueTag),
        .pc(issuePc), .srcA(srcA), .srcB(srcB), .imm(imm),
        .flushTaken(flushTaken), .flushSqN(flushSqN),
        .resValid(aluValid), .resTag(aluTag), .resSqN(aluSqN), .resResult(aluResult),
        .provTaken(provTaken), .provSqN(provSqN), .provTarget(provTarget)
    );

    divider div_i (
        .clk(clk), .reset(reset),
        .start(startDiv), .op(issueOp), .sqN(issueSqN), .tag(issueTag),
        .dividend(srcA), .divisor(srcB),
        .flushTaken(flushTaken), .flushSqN(flushSqN),
        .busy(divBusy), .resValid(divValid), .resTag(divTag), .resResult(divResult)
    );

    assign doNotIssue = divBusy;  // covers issue edge through the result cycle
    assign aluLive = aluValid && !(flushTaken && isYounger(aluSqN, flushSqN));
    assign wbValid = aluLive || divValid;
    assign wbTag = aluLive ? aluTag : divTag;
    assign wbResult = aluLive ? aluResult : divResult;

    wbClash: assert property (@(posedge clk) disable iff (reset) !(aluValid && divValid))
        else $error("alu and divider collide on port 0 writeback");

endmodule

/* src/aluMulLane.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module aluMulLane (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    issueValid,
    input  wire [`OP_WIDTH-1:0]    issueOp,
    input  wire [`SQN_WIDTH-1:0]   issueSqN,
    input  wire [`TAG_WIDTH-1:0]   issueTag,
    input  wire [`XLEN-1:0]        issuePc,
    input  wire [`XLEN-1:0]        srcA,
    input  wire [`XLEN-1:0]        srcB,
    input  execPkg::OperandWord    imm,
    input  wire                    flushTaken,
    input  wire [`SQN_WIDTH-1:0]   flushSqN,
    output logic                   doNotIssue,
    output logic                   wbValid,
    output logic [`TAG_WIDTH-1:0]  wbTag,
    output logic [`XLEN-1:0]       wbResult,
    output logic                   provTaken,
    output logic [`SQN_WIDTH-1:0]  provSqN,
    output logic [`XLEN-1:0]       provTarget
);
    import execPkg::*;

    logic aluValid, aluLive, mulValid, mulLast, isMul, startMul;
    logic [`TAG_WIDTH-1:0] aluTag, mulTag;
    logic [`SQN_WIDTH-1:0] aluSqN;
    logic [`XLEN-1:0] aluResult, mulResult;

    assign isMul = (issueOp >= `OP_MUL) && (issueOp <= `OP_MULHU);
    assign startMul = issueValid && isMul;  // multiplier drops a younger start itself

    intAlu alu_i (
        .clk(clk), .reset(reset),
        .issueValid(issueValid), .op(issueOp), .sqN(issueSqN), .tag(issueTag),
        .pc(issuePc), .srcA(srcA), .srcB(srcB), .imm(imm),
        .flushTaken(flushTaken), .flushSqN(flushSqN),
        .resValid(aluValid), .resTag(aluTag), .resSqN(aluSqN), .resResult(aluResult),
        .provTaken(provTaken), .provSqN(provSqN), .provTarget(provTarget)
    );

    multiplier mul_i (
        .clk(clk), .reset(reset),
        .start(startMul), .op(issueOp), .sqN(issueSqN), .tag(issueTag),
        .srcA(srcA), .srcB(srcB),
        .flushTaken(flushTaken), .flushSqN(flushSqN),
        .lastStageValid(mulLast), .resValid(mulValid), .resTag(mulTag), .resResult(mulResult)
    );

    assign doNotIssue = mulLast;  // slot after this edge belongs to the multiplier
    assign aluLive = aluValid && !(flushTaken && isYounger(aluSqN, flushSqN));
    assign wbValid = aluLive || mulValid;
    assign wbTag = aluLive ? aluTag : mulTag;
    assign wbResult = aluLive ? aluResult : mulResult;

    wbClash: assert property (@(posedge clk) disable iff (reset) !(aluValid && mulValid))
        else $error("alu and multiplier collide on port 1 writeback");

endmodule

/* src/branchSelector.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module branchSelector (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    provTaken0,
    input  wire [`SQN_WIDTH-1:0]   provSqN0,
    input  wire [`XLEN-1:0]        provTarget0,
    input  wire                    provTaken1,
    input  wire [`SQN_WIDTH-1:0]   provSqN1,
    input  wire [`XLEN-1:0]        provTarget1,
    output logic                   branchTaken,
    output logic [`SQN_WIDTH-1:0]  branchSqN,
    output logic [`XLEN-1:0]       branchTarget
);
    import execPkg::*;

    logic take0, take1, pick1;

    always_comb begin
        // anything younger than the branch in flight is already dead
        take0 = provTaken0 && !(branchTaken && isYounger(provSqN0, branchSqN));
        take1 = provTaken1 && !(branchTaken && isYounger(provSqN1, branchSqN));
        pick1 = take1 && (!take0 || isYounger(provSqN0, provSqN1));
    end

    always_ff @(posedge clk) begin
        if (reset)
            branchTaken <= 1'b0;
        else
            branchTaken <= take0 || take1;
        branchSqN <= pick1 ? provSqN1 : provSqN0;
        branchTarget <= pick1 ? provTarget1 : provTarget0;
    end

    // a resolved branch is reported exactly once
    noRepeat: assert property (@(posedge clk) disable iff (reset)
        (branchTaken ##1 branchTaken) |-> branchSqN != $past(branchSqN))
        else $error("branch %0d reported twice", branchSqN);

endmodule

/* src/divider.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module divider (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    start,
    input  wire [`OP_WIDTH-1:0]    op,
    input  wire [`SQN_WIDTH-1:0]   sqN,
    input  wire [`TAG_WIDTH-1:0]   tag,
    input  wire [`XLEN-1:0]        dividend,
    input  wire [`XLEN-1:0]        divisor,
    input  wire                    flushTaken,
    input  wire [`SQN_WIDTH-1:0]   flushSqN,
    output logic                   busy,
    output logic                   resValid,
    output logic [`TAG_WIDTH-1:0]  resTag,
    output logic [`XLEN-1:0]       resResult
);
    import execPkg::*;

    localparam int CNT_WIDTH = $clog2(`DIV_LATENCY);

    logic [CNT_WIDTH-1:0] count;
    logic [`SQN_WIDTH-1:0] curSqN;
    logic [`XLEN-1:0] quot, rem, dvsAbs, dvdSaved;
    logic [`XLEN:0] shifted, diff;
    logic signedOp, negQ, negR, divZero, isRem, killed, done;

    assign signedOp = (op == `OP_DIV) || (op == `OP_REM);
    assign killed = flushTaken && isYounger(curSqN, flushSqN);
    assign done = busy && (count == '0);
    assign resValid = done && !killed;
    assign shifted = {rem, quot[`XLEN-1]};
    assign diff = shifted - {1'b0, dvsAbs};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= CNT_WIDTH'(`DIV_LATENCY - 1);
        end else if (killed || done) begin
            busy <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // restoring division on magnitudes, quotient shifts in from the right
    always_ff @(posedge clk) begin
        if (start) begin
            curSqN <= sqN;
            resTag <= tag;
            dvdSaved <= dividend;
            quot <= (signedOp && dividend[`XLEN-1]) ? -dividend : dividend;
            rem <= '0;
            dvsAbs <= (signedOp && divisor[`XLEN-1]) ? -divisor : divisor;
            negQ <= signedOp && (dividend[`XLEN-1] ^ divisor[`XLEN-1]);
            negR <= signedOp && dividend[`XLEN-1];
            divZero <= divisor == '0;
            isRem <= (op == `OP_REM) || (op == `OP_REMU);
        end else if (busy && count != '0) begin
            if (!diff[`XLEN]) begin
                rem <= diff[`XLEN-1:0];
                quot <= {quot[`XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[`XLEN-1:0];
                quot <= {quot[`XLEN-2:0], 1'b0};
            end
        end
    end

    // sign fix-up; overflow already yields dividend / 0
    always_comb begin
        if (isRem)
            resResult = divZero ? dvdSaved : (negR ? -rem : rem);
        else
            resResult = divZero ? '1 : (negQ ? -quot : quot);
    end

    startWhileBusy: assert property (@(posedge clk) disable iff (reset) busy |-> !start)
        else $error("divider started while busy");

endmodule

/* src/execPkg.sv */
`include "exec_settings.svh"

package execPkg;

    // second operand word, either a plain value or a branch descriptor
    typedef union packed {
        logic [`XLEN-1:0] full;
        struct packed {
            logic        predTaken;
            logic [19:0] offset;   // signed, byte units
            logic [10:0] pad;
        } branch;
    } OperandWord;

    // true when a is younger than b
    function automatic logic isYounger(input logic [`SQN_WIDTH-1:0] a,
                                       input logic [`SQN_WIDTH-1:0] b);
        logic [`SQN_WIDTH-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

/* src/intAlu.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module intAlu (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    issueValid,
    input  wire [`OP_WIDTH-1:0]    op,
    input  wire [`SQN_WIDTH-1:0]   sqN,
    input  wire [`TAG_WIDTH-1:0]   tag,
    input  wire [`XLEN-1:0]        pc,
    input  wire [`XLEN-1:0]        srcA,
    input  wire [`XLEN-1:0]        srcB,
    input  execPkg::OperandWord    imm,
    input  wire                    flushTaken,
    input  wire [`SQN_WIDTH-1:0]   flushSqN,
    output logic                   resValid,
    output logic [`TAG_WIDTH-1:0]  resTag,
    output logic [`SQN_WIDTH-1:0]  resSqN,
    output logic [`XLEN-1:0]       resResult,
    output logic                   provTaken,
    output logic [`SQN_WIDTH-1:0]  provSqN,
    output logic [`XLEN-1:0]       provTarget
);
    import execPkg::*;

    logic isAlu, isBranch, accept, actualTaken, provValid;
    logic [`XLEN-1:0] aluOut, offsetExt, target;
    logic [$clog2(`XLEN)-1:0] shamt;

    assign isAlu = issueValid && (op <= `OP_SRA);
    assign isBranch = issueValid && (op >= `OP_BEQ) && (op <= `OP_BGEU);
    assign accept = !(flushTaken && isYounger(sqN, flushSqN)); // squash younger issue
    assign shamt = imm.full[$clog2(`XLEN)-1:0];
    assign offsetExt = {{(`XLEN-20){imm.branch.offset[19]}}, imm.branch.offset};

    always_comb begin
        case (op)
            `OP_ADD:  aluOut = srcA + imm.full;
            `OP_SUB:  aluOut = srcA - imm.full;
            `OP_AND:  aluOut = srcA & imm.full;
            `OP_OR:   aluOut = srcA | imm.full;
            `OP_XOR:  aluOut = srcA ^ imm.full;
            `OP_SLT:  aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(imm.full)};
            `OP_SLTU: aluOut = {{(`XLEN-1){1'b0}}, srcA < imm.full};
            `OP_SLL:  aluOut = srcA << shamt;
            `OP_SRL:  aluOut = srcA >> shamt;
            `OP_SRA:  aluOut = $signed(srcA) >>> shamt;
            default:  aluOut = '0;
        endcase
    end

    always_comb begin
        case (op)
            `OP_BEQ:  actualTaken = srcA == srcB;
            `OP_BNE:  actualTaken = srcA != srcB;
            `OP_BLT:  actualTaken = $signed(srcA) < $signed(srcB);
            `OP_BGE:  actualTaken = $signed(srcA) >= $signed(srcB);
            `OP_BLTU: actualTaken = srcA < srcB;
            `OP_BGEU: actualTaken = srcA >= srcB;
            default:  actualTaken = 1'b0;
        endcase
        target = actualTaken ? pc + offsetExt : pc + 4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resValid <= 1'b0;
            provValid <= 1'b0;
        end else begin
            resValid <= isAlu && accept;
            provValid <= isBranch && accept && (actualTaken != imm.branch.predTaken);
        end
        resTag <= tag;
        resSqN <= sqN;
        resResult <= aluOut;
        provSqN <= sqN;
        provTarget <= target;
    end

    // younger mispredicts die while an older branch flushes
    assign provTaken = provValid && !(flushTaken && isYounger(provSqN, flushSqN));

endmodule

/* src/intExecCluster.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module intExecCluster (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    issueValid0,
    input  wire [`OP_WIDTH-1:0]    issueOp0,
    input  wire [`SQN_WIDTH-1:0]   issueSqN0,
    input  wire [`TAG_WIDTH-1:0]   issueTag0,
    input  wire [`XLEN-1:0]        issuePc0,
    input  wire [`XLEN-1:0]        srcA0,
    input  wire [`XLEN-1:0]        srcB0,
    input  execPkg::OperandWord    imm0,
    input  wire                    issueValid1,
    input  wire [`OP_WIDTH-1:0]    issueOp1,
    input  wire [`SQN_WIDTH-1:0]   issueSqN1,
    input  wire [`TAG_WIDTH-1:0]   issueTag1,
    input  wire [`XLEN-1:0]        issuePc1,
    input  wire [`XLEN-1:0]        srcA1,
    input  wire [`XLEN-1:0]        srcB1,
    input  execPkg::OperandWord    imm1,
    output logic                   doNotIssue0,
    output logic                   wbValid0,
    output logic [`TAG_WIDTH-1:0]  wbTag0,
    output logic [`XLEN-1:0]       wbResult0,
    output logic                   doNotIssue1,
    output logic                   wbValid1,
    output logic [`TAG_WIDTH-1:0]  wbTag1,
    output logic [`XLEN-1:0]       wbResult1,
    output logic                   branchTaken,
    output logic [`SQN_WIDTH-1:0]  branchSqN,
    output logic [`XLEN-1:0]       branchTarget
);

    logic provTaken0, provTaken1;
    logic [`SQN_WIDTH-1:0] provSqN0, provSqN1;
    logic [`XLEN-1:0] provTarget0, provTarget1;

    aluDivLane lane0_i (
        .clk(clk), .reset(reset),
        .issueValid(issueValid0), .issueOp(issueOp0), .issueSqN(issueSqN0),
        .issueTag(issueTag0), .issuePc(issuePc0), .srcA(srcA0), .srcB(srcB0), .imm(imm0),
        .flushTaken(branchTaken), .flushSqN(branchSqN),
        .doNotIssue(doNotIssue0), .wbValid(wbValid0), .wbTag(wbTag0), .wbResult(wbResult0),
        .provTaken(provTaken0), .provSqN(provSqN0), .provTarget(provTarget0)
    );

    aluMulLane lane1_i (
        .clk(clk), .reset(reset),
        .issueValid(issueValid1), .issueOp(issueOp1), .issueSqN(issueSqN1),
        .issueTag(issueTag1), .issuePc(issuePc1), .srcA(srcA1), .srcB(srcB1), .imm(imm1),
        .flushTaken(branchTaken), .flushSqN(branchSqN),
        .doNotIssue(doNotIssue1), .wbValid(wbValid1), .wbTag(wbTag1), .wbResult(wbResult1),
        .provTaken(provTaken1), .provSqN(provSqN1), .provTarget(provTarget1)
    );

    branchSelector bsel_i (
        .clk(clk), .reset(reset),
        .provTaken0(provTaken0), .provSqN0(provSqN0), .provTarget0(provTarget0),
        .provTaken1(provTaken1), .provSqN1(provSqN1), .provTarget1(provTarget1),
        .branchTaken(branchTaken), .branchSqN(branchSqN), .branchTarget(branchTarget)
    );

endmodule

/* src/multiplier.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module multiplier (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    start,
    input  wire [`OP_WIDTH-1:0]    op,
    input  wire [`SQN_WIDTH-1:0]   sqN,
    input  wire [`TAG_WIDTH-1:0]   tag,
    input  wire [`XLEN-1:0]        srcA,
    input  wire [`XLEN-1:0]        srcB,
    input  wire                    flushTaken,
    input  wire [`SQN_WIDTH-1:0]   flushSqN,
    output logic                   lastStageValid,
    output logic                   resValid,
    output logic [`TAG_WIDTH-1:0]  resTag,
    output logic [`XLEN-1:0]       resResult
);
    import execPkg::*;

    localparam int LAST = `MUL_LATENCY - 1;

    logic [LAST:0] valid, live;
    logic [`SQN_WIDTH-1:0] sqNs [`MUL_LATENCY];
    logic [`TAG_WIDTH-1:0] tags [`MUL_LATENCY];
    logic [`OP_WIDTH-1:0] op0, op1;
    logic signed [`XLEN:0] opA, opB;
    logic signed [2*`XLEN+1:0] product;

    always_comb begin
        for (int i = 0; i <= LAST; i++)
            live[i] = valid[i] && !(flushTaken && isYounger(sqNs[i], flushSqN));
    end

    assign lastStageValid = live[LAST-1];  // enters the result stage on the next edge
    assign resValid = live[LAST];
    assign resTag = tags[LAST];

    always_ff @(posedge clk) begin
        if (reset)
            valid <= '0;
        else
            valid <= {live[LAST-1:0], start && !(flushTaken && isYounger(sqN, flushSqN))};
    end

    always_ff @(posedge clk) begin
        sqNs[0] <= sqN;
        tags[0] <= tag;
        op0 <= op;
        opA <= {(op != `OP_MULHU) && srcA[`XLEN-1], srcA};  // MULHU zero extends
        opB <= {(op != `OP_MULHU) && srcB[`XLEN-1], srcB};
        for (int i = 1; i <= LAST; i++) begin
            sqNs[i] <= sqNs[i-1];
            tags[i] <= tags[i-1];
        end
        op1 <= op0;
        product <= opA * opB;
        resResult <= (op1 == `OP_MUL) ? product[`XLEN-1:0] : product[2*`XLEN-1:`XLEN];
    end

endmodule

/* verification/clusterTb.sv */
`timescale 1ns/100ps
`include "exec_settings.svh"

module clusterTb;
    import execPkg::*;

    // reset, aluOps, branchResolve, multiply, divide, flushOldest, then margin
    localparam int MAX_CYCLES = 9 + 10 + 36 + 6 + 8 * (`DIV_LATENCY + 1) + 8 + 59;

    logic clk, reset;
    logic issueValid0, issueValid1;
    logic [`OP_WIDTH-1:0] issueOp0, issueOp1;
    logic [`SQN_WIDTH-1:0] issueSqN0, issueSqN1;
    logic [`TAG_WIDTH-1:0] issueTag0, issueTag1;
    logic [`XLEN-1:0] issuePc0, issuePc1, srcA0, srcA1, srcB0, srcB1;
    OperandWord imm0, imm1;
    logic doNotIssue0, doNotIssue1, wbValid0, wbValid1, branchTaken;
    logic [`TAG_WIDTH-1:0] wbTag0, wbTag1;
    logic [`XLEN-1:0] wbResult0, wbResult1, branchTarget;
    logic [`SQN_WIDTH-1:0] branchSqN;

    logic [31:0] lfsr;
    logic [`SQN_WIDTH-1:0] sqNext;
    string curTest;
    int errors = 0;
    int checks = 0;
    int testErrors = 0;
    int testsRun = 0;
    int cycles;

    intExecCluster dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    function automatic logic [31:0] aluModel(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            `OP_ADD:  return a + b;
            `OP_SUB:  return a - b;
            `OP_AND:  return a & b;
            `OP_OR:   return a | b;
            `OP_XOR:  return a ^ b;
            `OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `OP_SLL:  return a << b[4:0];
            `OP_SRL:  return a >> b[4:0];
            `OP_SRA:  return $signed(a) >>> b[4:0];
            default:  return 32'hx;
        endcase
    endfunction

    function automatic logic branchModel(input logic [4:0] op, input logic [31:0] a, b);
        case (op)
            `OP_BEQ:  return a == b;
            `OP_BNE:  return a != b;
            `OP_BLT:  return $signed(a) < $signed(b);
            `OP_BGE:  return $signed(a) >= $signed(b);
            `OP_BLTU: return a < b;
            default:  return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] mulModel(input logic [4:0] op, input logic [31:0] a, b);
        logic [63:0] ss, uu;
        ss = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of the signed product
        uu = {32'b0, a} * {32'b0, b};
        if (op == `OP_MUL)
            return ss[31:0];
        return (op == `OP_MULH) ? ss[63:32] : uu[63:32];
    endfunction

    function automatic logic [31:0] divModel(input logic [4:0] op, input logic [31:0] a, b);
        logic isSigned;
        isSigned = (op == `OP_DIV) || (op == `OP_REM);
        if (b == 0)
            return (op == `OP_DIV || op == `OP_DIVU) ? 32'hFFFF_FFFF : a;
        if (isSigned && a == 32'h8000_0000 && b == 32'hFFFF_FFFF)
            return (op == `OP_DIV) ? a : 32'd0;
        case (op)
            `OP_DIV:  return $signed(a) / $signed(b);
            `OP_DIVU: return a / b;
            `OP_REM:  return $signed(a) % $signed(b);
            default:  return a % b;
        endcase
    endfunction

    task automatic expectEq(input string what, input logic [31:0] want, input logic [31:0] got);
        checks++;
        assert (got === want)
        else begin
            errors++;
            testErrors++;
            $display("MISMATCH %s %s expected %h actual %h", curTest, what, want, got);
        end
    endtask

    task automatic expectTrue(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1)
        else begin
            errors++;
            testErrors++;
            $display("%s: %s", curTest, msg);
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        testsRun++;
        $display("%s finished with %0d errors", curTest, testErrors);
    endtask

    task automatic issue(input int port, input logic [4:0] op, input logic [6:0] sqN,
                         input logic [5:0] tag, input logic [31:0] pc, a, b, immWord);
        if (port == 0) begin
            issueValid0 = 1'b1;
            issueOp0 = op;
            issueSqN0 = sqN;
            issueTag0 = tag;
            issuePc0 = pc;
            srcA0 = a;
            srcB0 = b;
            imm0.full = immWord;
        end else begin
            issueValid1 = 1'b1;
            issueOp1 = op;
            issueSqN1 = sqN;
            issueTag1 = tag;
            issuePc1 = pc;
            srcA1 = a;
            srcB1 = b;
            imm1.full = immWord;
        end
    endtask

    task automatic idle();
        issueValid0 = 1'b0;
        issueValid1 = 1'b0;
    endtask

    task automatic aluOps();
        logic [31:0] a0, b0, a1, b1;
        logic [5:0] tag0, tag1;
        startTest("aluOps");
        for (int op = `OP_ADD; op <= `OP_SRA; op++) begin
            a0 = randBits(32);
            b0 = randBits(32);
            a1 = randBits(32);
            b1 = randBits(32);
            tag0 = randBits(6);
            tag1 = randBits(6);
            issue(0, op[4:0], sqNext, tag0, 0, a0, randBits(32), b0);  // operand b rides in imm
            issue(1, op[4:0], sqNext + 7'd1, tag1, 0, a1, randBits(32), b1);
            sqNext += 7'd2;
            @(negedge clk);
            expectEq("wbValid0", 1, wbValid0);
            expectEq("wbTag0", tag0, wbTag0);
            expectEq("wbResult0", aluModel(op[4:0], a0, b0), wbResult0);
            expectEq("wbValid1", 1, wbValid1);
            expectEq("wbTag1", tag1, wbTag1);
            expectEq("wbResult1", aluModel(op[4:0], a1, b1), wbResult1);
        end
        idle();
        endTest();
    endtask

    task automatic branchResolve();
        OperandWord w;
        logic [31:0] a, b, pc, target;
        logic [6:0] sqN;
        logic taken, wrong;
        int port;
        startTest("branchResolve");
        for (int op = `OP_BEQ; op <= `OP_BGEU; op++) begin
            a = randBits(32);
            b = randBits(1) ? a : randBits(32);
            pc = randBits(30) << 2;
            w.full = randBits(32);
            taken = branchModel(op[4:0], a, b);
            target = taken ? pc + {{12{w.branch.offset[19]}}, w.branch.offset} : pc + 32'd4;
            for (int p = 0; p < 2; p++) begin
                w.branch.predTaken = p[0];
                wrong = taken != p[0];
                port = (op + p) % 2;
                sqN = sqNext;
                sqNext++;
                issue(port, op[4:0], sqN, randBits(6), pc, a, b, w.full);
                @(negedge clk);
                idle();
                expectEq("branchTaken early", 0, branchTaken);
                expectEq("branch writeback", 0, port ? wbValid1 : wbValid0);
                @(negedge clk);
                expectEq("branchTaken", wrong, branchTaken);
                if (wrong) begin
                    expectEq("branchSqN", sqN, branchSqN);
                    expectEq("branchTarget", target, branchTarget);
                end
                @(negedge clk);
                expectEq("branchTaken late", 0, branchTaken);
            end
        end
        endTest();
    endtask

    task automatic multiply();
        logic [4:0] ops [3];
        logic [31:0] want [3];
        logic [5:0] tags [3];
        logic [31:0] a, b;
        startTest("multiply");
        ops = '{`OP_MUL, `OP_MULH, `OP_MULHU};
        for (int k = 0; k < 6; k++) begin
            if (k < 3) begin
                a = randBits(32);
                b = randBits(32);
                tags[k] = randBits(6);
                want[k] = mulModel(ops[k], a, b);
                issue(1, ops[k], sqNext, tags[k], 0, a, b, 0);
                sqNext++;
            end else begin
                idle();
            end
            @(negedge clk);
            expectEq("doNotIssue1", k >= 1 && k <= 3, doNotIssue1);
            expectEq("wbValid1", k >= 2 && k <= 4, wbValid1);
            if (k >= 2 && k <= 4) begin
                expectEq("wbTag1", tags[k-2], wbTag1);
                expectEq("wbResult1", want[k-2], wbResult1);
            end
        end
        endTest();
    endtask

    task automatic divide();
        logic [4:0] ops [8];
        logic [31:0] dividends [8];
        logic [31:0] divisors [8];
        logic [31:0] want;
        logic [5:0] tag;
        int waited;
        startTest("divide");
        ops = '{`OP_DIV, `OP_DIVU, `OP_REM, `OP_REMU, `OP_DIV, `OP_REMU, `OP_DIV, `OP_REM};
        for (int i = 0; i < 8; i++) begin
            dividends[i] = randBits(32);
            divisors[i] = randBits(1) ? -randBits(12) : randBits(12);  // keeps quotients wide
        end
        divisors[4] = '0;
        divisors[5] = '0;
        dividends[6] = 32'h8000_0000;  // signed overflow
        divisors[6] = 32'hFFFF_FFFF;
        dividends[7] = 32'h8000_0000;
        divisors[7] = 32'hFFFF_FFFF;
        for (int i = 0; i < 8; i++) begin
            tag = randBits(6);
            want = divModel(ops[i], dividends[i], divisors[i]);
            expectEq("doNotIssue0 before issue", 0, doNotIssue0);
            issue(0, ops[i], sqNext, tag, 0, dividends[i], divisors[i], 0);
            sqNext++;
            waited = 0;
            do begin
                @(negedge clk);
                idle();
                waited++;
                expectEq("doNotIssue0", 1, doNotIssue0);
            end while (!wbValid0 && waited < `DIV_LATENCY + 4);
            expectTrue(wbValid0, "divider result never arrived");
            expectEq("divide latency", `DIV_LATENCY, waited);
            expectEq("wbTag0", tag, wbTag0);
            expectEq("wbResult0", want, wbResult0);
            @(negedge clk);
        end
        endTest();
    endtask

    task automatic flushOldest();
        OperandWord w0, w1;
        logic [31:0] a, b, olderMul, pc0, pc1, target;
        logic [6:0] s, olderBr, youngerBr;
        startTest("flushOldest");
        s = sqNext;
        olderBr = s + 7'd1;
        youngerBr = s + 7'd2;
        sqNext += 7'd6;
        a = randBits(32);
        b = randBits(32);
        olderMul = mulModel(`OP_MUL, a, b);
        issue(1, `OP_MUL, s, 6'd40, 0, a, b, 0);
        @(negedge clk);
        a = randBits(32);
        pc0 = randBits(30) << 2;
        pc1 = randBits(30) << 2;
        w0.full = randBits(32);
        w0.branch.predTaken = 1'b0;  // beq on equal operands is taken
        w1.full = randBits(32);
        w1.branch.predTaken = 1'b1;  // bne on equal operands is not
        target = pc0 + {{12{w0.branch.offset[19]}}, w0.branch.offset};
        issue(0, `OP_BEQ, olderBr, 6'd41, pc0, a, a, w0.full);
        issue(1, `OP_BNE, youngerBr, 6'd42, pc1, a, a, w1.full);
        @(negedge clk);
        issue(1, `OP_MUL, s + 7'd3, 6'd43, 0, a, b, 0);  // in flight when the flush hits
        issue(0, `OP_ADD, s + 7'd4, 6'd44, 0, a, 0, b);
        @(negedge clk);
        idle();
        expectEq("branchTaken", 1, branchTaken);
        expectEq("branchSqN", olderBr, branchSqN);
        expectEq("branchTarget", target, branchTarget);
        expectEq("older wbValid1", 1, wbValid1);
        expectEq("older wbTag1", 40, wbTag1);
        expectEq("older wbResult1", olderMul, wbResult1);
        expectEq("younger wbValid0", 0, wbValid0);
        issue(0, `OP_ADD, s + 7'd5, 6'd45, 0, a, 0, b);  // issued during the flush
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            idle();
            expectEq("second branchTaken", 0, branchTaken);
            expectEq("younger wbValid0", 0, wbValid0);
            expectEq("younger wbValid1", 0, wbValid1);
        end
        endTest();
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles before the tests completed", cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        lfsr = 32'd1944;
        sqNext = '0;
        issue(0, 0, 0, 0, 0, 0, 0, 0);
        issue(1, 0, 0, 0, 0, 0, 0, 0);
        idle();
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        aluOps();
        branchResolve();
        multiply();
        divide();
        flushOldest();
        $display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
